/* qa_driver.f */
common/qa_pkg.sv
rtl/qa_driver_csr.sv
rtl/qa_sreg_file.sv
rtl/qa_test_engine.sv
rtl/qa_top.sv
verif/qa_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= qa_tb
FILELIST  ?= qa_driver.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/qa_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for qa_top, a cycle model of the CSR state with concurrent checks against it
module qa_tb import qa_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    // Upper bound on the host writes issued by all tests together
    localparam int WRITE_BUDGET = 48;

    // Expected test engine activity, one beat per cycle while active
    typedef struct packed {
        logic        active;
        logic        start;
        logic [15:0] idx;
        logic [15:0] total;
        logic [63:0] rd_base;
        logic [63:0] wr_base;
    } t_stream_model;

    // Expected status counters and the response in flight
    typedef struct packed {
        logic [31:0] writes;
        logic [31:0] started;
        logic [31:0] done;
        logic        rsp_valid;
        logic [31:0] rsp_data;
    } t_status_model;

    logic           clk;
    logic           rst;
    t_csr_write     wr;
    t_csr_afu_state csr;
    t_mem_req       mem_req;
    logic           sreg_rsp_valid;
    logic [31:0]    sreg_rsp_data;

    t_csr_afu_state m_csr;
    // High halves written, bit 0 for DSM and bit 1 for context
    logic [1:0]     m_hi_seen;
    t_status_model  m_stat;
    t_stream_model  m_strm;
    logic           m_last;
    logic [127:0]   m_beat_addr;

    logic [15:0]    counts [5];
    int             beat_sum;
    int             limit_cycles;
    int             errors = 0;
    int             err_mark = 0;
    int             tests_run = 0;
    int             tests_failed = 0;

    qa_top DUT (
        .clk            (clk),
        .rst            (rst),
        .wr             (wr),
        .csr            (csr),
        .mem_req        (mem_req),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Beat idx of a stream sits idx strides above both frame bases
    assign m_last      = m_strm.active && (m_strm.idx == m_strm.total - 16'd1);
    assign m_beat_addr = {m_strm.rd_base + 64'(m_strm.idx) * 64'(FRAME_STRIDE),
                          m_strm.wr_base + 64'(m_strm.idx) * 64'(FRAME_STRIDE)};

    // Status word i as held just before the response edge
    function automatic logic [31:0] status_value(t_sreg_addr i);
        case (i)
            2'd0:    return m_stat.writes;
            2'd1:    return m_stat.started;
            2'd2:    return m_stat.done;
            default: return m_csr.afu_dsm_base[31:0];
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            m_csr     <= '0;
            m_hi_seen <= '0;
            m_stat    <= '0;
            m_strm    <= '0;
        end else begin
            // Strobes only in the cycle right after their own write
            m_csr.afu_enable_test.pulse <= wr.valid && wr.addr == CSR_AFU_ENABLE_TEST;
            m_csr.afu_sreg_req.enable   <= wr.valid && wr.addr == CSR_AFU_SREG_READ;
            if (wr.valid) begin
                m_stat.writes <= m_stat.writes + 32'd1;
                case (wr.addr)
                    CSR_AFU_DSM_BASEL:         m_csr.afu_dsm_base[31:0]      <= wr.data;
                    CSR_AFU_DSM_BASEH:         m_csr.afu_dsm_base[63:32]     <= wr.data;
                    CSR_AFU_CNTXT_BASEL:       m_csr.afu_cntxt_base[31:0]    <= wr.data;
                    CSR_AFU_CNTXT_BASEH:       m_csr.afu_cntxt_base[63:32]   <= wr.data;
                    CSR_AFU_EN: begin
                        m_csr.afu_en              <= wr.data[0];
                        m_csr.afu_en_user_channel <= wr.data[1];
                    end
                    CSR_AFU_ENABLE_TEST:       m_csr.afu_enable_test.count   <= wr.data[15:0];
                    CSR_AFU_SREG_READ:         m_csr.afu_sreg_req.addr       <= wr.data[1:0];
                    CSR_AFU_READ_FRAME_BASEL:  m_csr.afu_read_frame[31:0]    <= wr.data;
                    CSR_AFU_READ_FRAME_BASEH:  m_csr.afu_read_frame[63:32]   <= wr.data;
                    CSR_AFU_WRITE_FRAME_BASEL: m_csr.afu_write_frame[31:0]   <= wr.data;
                    CSR_AFU_WRITE_FRAME_BASEH: m_csr.afu_write_frame[63:32]  <= wr.data;
                    default: ;
                endcase
                // A low-half write makes the base valid
                if (wr.addr == CSR_AFU_DSM_BASEL) m_csr.afu_dsm_base_valid <= 1'b1;
                if (wr.addr == CSR_AFU_CNTXT_BASEL) m_csr.afu_cntxt_base_valid <= 1'b1;
                if (wr.addr == CSR_AFU_DSM_BASEH) m_hi_seen[0] <= 1'b1;
                if (wr.addr == CSR_AFU_CNTXT_BASEH) m_hi_seen[1] <= 1'b1;
            end
            m_stat.started   <= m_stat.started + 32'(m_strm.start);
            m_stat.done      <= m_stat.done + 32'(m_last);
            m_stat.rsp_valid <= m_csr.afu_sreg_req.enable;
            if (m_csr.afu_sreg_req.enable) m_stat.rsp_data <= status_value(m_csr.afu_sreg_req.addr);
            // Commands count only when idle, enabled and nonzero
            m_strm.start <= 1'b0;
            if (!m_strm.active) begin
                if (m_csr.afu_enable_test.pulse && m_csr.afu_en
                        && m_csr.afu_enable_test.count != 16'd0) begin
                    m_strm.active  <= 1'b1;
                    m_strm.start   <= 1'b1;
                    m_strm.idx     <= 16'd0;
                    m_strm.total   <= m_csr.afu_enable_test.count;
                    m_strm.rd_base <= m_csr.afu_read_frame;
                    m_strm.wr_base <= m_csr.afu_write_frame;
                end
            end else if (m_last || !m_csr.afu_en) begin
                m_strm.active <= 1'b0;
            end else begin
                m_strm.idx <= m_strm.idx + 16'd1;
            end
        end
    end

    a_afu_en: assert property (@(posedge clk) disable iff (rst) csr.afu_en == m_csr.afu_en)
        else mismatch("csr.afu_en", 128'($sampled(m_csr.afu_en)), 128'($sampled(csr.afu_en)));
    a_user_channel: assert property (@(posedge clk) disable iff (rst)
        csr.afu_en_user_channel == m_csr.afu_en_user_channel)
        else mismatch("csr.afu_en_user_channel", 128'($sampled(m_csr.afu_en_user_channel)),
                      128'($sampled(csr.afu_en_user_channel)));
    a_dsm_valid: assert property (@(posedge clk) disable iff (rst)
        csr.afu_dsm_base_valid == m_csr.afu_dsm_base_valid)
        else mismatch("csr.afu_dsm_base_valid", 128'($sampled(m_csr.afu_dsm_base_valid)),
                      128'($sampled(csr.afu_dsm_base_valid)));
    a_cntxt_valid: assert property (@(posedge clk) disable iff (rst)
        csr.afu_cntxt_base_valid == m_csr.afu_cntxt_base_valid)
        else mismatch("csr.afu_cntxt_base_valid", 128'($sampled(m_csr.afu_cntxt_base_valid)),
                      128'($sampled(csr.afu_cntxt_base_valid)));
    // Full bases are compared once both halves have been written
    a_dsm_base: assert property (@(posedge clk) disable iff (rst)
        m_hi_seen[0] && m_csr.afu_dsm_base_valid |-> csr.afu_dsm_base == m_csr.afu_dsm_base)
        else mismatch("csr.afu_dsm_base", 128'($sampled(m_csr.afu_dsm_base)),
                      128'($sampled(csr.afu_dsm_base)));
    a_cntxt_base: assert property (@(posedge clk) disable iff (rst)
        m_hi_seen[1] && m_csr.afu_cntxt_base_valid |-> csr.afu_cntxt_base == m_csr.afu_cntxt_base)
        else mismatch("csr.afu_cntxt_base", 128'($sampled(m_csr.afu_cntxt_base)),
                      128'($sampled(csr.afu_cntxt_base)));
    a_test_pulse: assert property (@(posedge clk) disable iff (rst)
        csr.afu_enable_test.pulse == m_csr.afu_enable_test.pulse)
        else mismatch("csr.afu_enable_test.pulse", 128'($sampled(m_csr.afu_enable_test.pulse)),
                      128'($sampled(csr.afu_enable_test.pulse)));
    a_sreg_en: assert property (@(posedge clk) disable iff (rst)
        csr.afu_sreg_req.enable == m_csr.afu_sreg_req.enable)
        else mismatch("csr.afu_sreg_req.enable", 128'($sampled(m_csr.afu_sreg_req.enable)),
                      128'($sampled(csr.afu_sreg_req.enable)));
    a_rsp_valid: assert property (@(posedge clk) disable iff (rst)
        sreg_rsp_valid == m_stat.rsp_valid)
        else mismatch("sreg_rsp_valid", 128'($sampled(m_stat.rsp_valid)),
                      128'($sampled(sreg_rsp_valid)));
    a_rsp_data: assert property (@(posedge clk) disable iff (rst)
        m_stat.rsp_valid |-> sreg_rsp_data == m_stat.rsp_data)
        else mismatch("sreg_rsp_data", 128'($sampled(m_stat.rsp_data)),
                      128'($sampled(sreg_rsp_data)));
    a_beat_valid: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid == m_strm.active)
        else mismatch("mem_req.valid", 128'($sampled(m_strm.active)),
                      128'($sampled(mem_req.valid)));
    // Read address in the upper half, write address in the lower
    a_beat_addr: assert property (@(posedge clk) disable iff (rst)
        m_strm.active |-> {mem_req.rd_addr, mem_req.wr_addr} == m_beat_addr)
        else mismatch("mem_req.rd_addr/wr_addr", $sampled(m_beat_addr),
                      $sampled({mem_req.rd_addr, mem_req.wr_addr}));

    task automatic mismatch(string name, logic [127:0] exp, logic [127:0] got);
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, got);
        errors++;
    endtask

    // Each write holds the strobe for exactly one clock
    task automatic write_csr(t_csr_addr a, logic [31:0] d);
        @(negedge clk);
        wr = '{valid: 1'b1, addr: a, data: d};
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            wr.valid = 1'b0;
        end
    endtask

    task automatic read_sreg(t_sreg_addr i);
        write_csr(CSR_AFU_SREG_READ, {30'h0, i});
        idle(3);
    endtask

    // Waits for beats to appear and then drain
    task automatic wait_stream_end(int max_cycles);
        int n;
        n = 0;
        idle(1);
        while (!mem_req.valid && n < max_cycles) begin
            idle(1);
            n++;
        end
        while (mem_req.valid && n < max_cycles) begin
            idle(1);
            n++;
        end
        if (n >= max_cycles) begin
            $display("Beat stream did not end within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic finish_test(string name);
        idle(3);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end else begin
            $display("test %s: ok", name);
        end
        err_mark = errors;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'h90cf_16e5));
        beat_sum = 0;
        foreach (counts[i]) begin
            counts[i] = 16'($urandom_range(12, 3));
            beat_sum += int'(counts[i]);
        end
        // Four cycles per write at most, one per beat, plus room for reset
        limit_cycles = 4 * WRITE_BUDGET + beat_sum + 64;
        fork
            begin
                #(limit_cycles * CLK_PERIOD);
                $display("Watchdog expired after %0d cycles", limit_cycles);
                $display("Test failed");
                $finish;
            end
        join_none
        rst = 1'b1;
        wr  = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        finish_test("reset state");

        write_csr(CSR_AFU_DSM_BASEL, $urandom);
        write_csr(CSR_AFU_DSM_BASEH, $urandom);
        write_csr(CSR_AFU_CNTXT_BASEL, $urandom);
        write_csr(CSR_AFU_CNTXT_BASEH, $urandom);
        finish_test("base registers");

        for (int i = 0; i < 4; i++) read_sreg(t_sreg_addr'(i));
        finish_test("status reads");

        write_csr(CSR_AFU_READ_FRAME_BASEL, $urandom);
        write_csr(CSR_AFU_READ_FRAME_BASEH, $urandom);
        write_csr(CSR_AFU_WRITE_FRAME_BASEL, $urandom);
        write_csr(CSR_AFU_WRITE_FRAME_BASEH, $urandom);
        // User channel on as well, so that both enable bits are seen high
        write_csr(CSR_AFU_EN, 32'h3);
        for (int k = 0; k < 2; k++) begin
            write_csr(CSR_AFU_ENABLE_TEST, {16'h0, counts[k]});
            wait_stream_end(2 * int'(counts[k]) + 8);
            read_sreg(2'd1);
            read_sreg(2'd2);
        end
        finish_test("frame streams");

        // Zero count, a command during a stream, then a command while disabled
        write_csr(CSR_AFU_ENABLE_TEST, 32'h0);
        idle(3);
        write_csr(CSR_AFU_ENABLE_TEST, {16'h0, counts[2]});
        idle(2);
        write_csr(CSR_AFU_ENABLE_TEST, {16'h0, counts[3]});
        wait_stream_end(2 * int'(counts[2]) + 8);
        write_csr(CSR_AFU_EN, 32'h0);
        write_csr(CSR_AFU_ENABLE_TEST, {16'h0, counts[3]});
        idle(4);
        read_sreg(2'd1);
        read_sreg(2'd2);
        finish_test("dropped commands");

        write_csr(CSR_AFU_EN, 32'h1);
        write_csr(CSR_AFU_SREG_READ, 32'h0);
        write_csr(CSR_AFU_SREG_READ, 32'h3);
        write_csr(CSR_AFU_ENABLE_TEST, {16'h0, counts[4]});
        write_csr(CSR_AFU_ENABLE_TEST, {16'h0, counts[4]});
        wait_stream_end(2 * int'(counts[4]) + 8);
        finish_test("back to back writes");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/qa_top.sv */
`timescale 1ns/1ps
`default_nettype none

// CSR decoder with its two consumers
module qa_top import qa_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  t_csr_write     wr,
    output t_csr_afu_state csr,
    output t_mem_req       mem_req,
    output logic           sreg_rsp_valid,
    output logic [31:0]    sreg_rsp_data
);

    // Test engine events counted by the status file
    logic test_start;
    logic test_done;

    qa_driver_csr u_driver_csr (
        .clk (clk),
        .rst (rst),
        .wr  (wr),
        .csr (csr)
    );

    // The raw write strobe feeds the write counter
    qa_sreg_file u_sreg_file (
        .clk            (clk),
        .rst            (rst),
        .csr_wr         (wr.valid),
        .csr            (csr),
        .test_start     (test_start),
        .test_done      (test_done),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

    qa_test_engine u_test_engine (
        .clk        (clk),
        .rst        (rst),
        .csr        (csr),
        .mem_req    (mem_req),
        .test_start (test_start),
        .test_done  (test_done)
    );

endmodule

`default_nettype wire

/* rtl/qa_test_engine.sv */
`timescale 1ns/1ps
`default_nettype none

// Streams frame addresses for a test of the commanded number of beats
module qa_test_engine import qa_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  t_csr_afu_state csr,
    output t_mem_req       mem_req,
    output logic           test_start,
    output logic           test_done
);

    logic        beat_valid;
    logic [15:0] beats_left;
    logic [63:0] rd_addr;
    logic [63:0] wr_addr;
    logic        start_ok;
    logic        next_beat;

    // A beat on the output means a test is running, so new commands are dropped
    assign start_ok = csr.afu_enable_test.pulse
                   && (csr.afu_enable_test.count != 16'd0)
                   && csr.afu_en
                   && !beat_valid;

    // Keep going while beats remain, clearing afu_en stops after this beat
    assign next_beat = beat_valid && (beats_left != 16'd0) && csr.afu_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid <= 1'b0;
            beats_left <= '0;
            test_start <= 1'b0;
            test_done  <= 1'b0;
        end else begin
            test_start <= start_ok;
            if (start_ok) begin
                beat_valid <= 1'b1;
                beats_left <= csr.afu_enable_test.count - 16'd1;
                // A single-beat test finishes on its first beat
                test_done  <= (csr.afu_enable_test.count == 16'd1);
            end else if (next_beat) begin
                beats_left <= beats_left - 16'd1;
                test_done  <= (beats_left == 16'd1);
            end else begin
                beat_valid <= 1'b0;
                test_done  <= 1'b0;
            end
        end
    end

    // Addresses walk up from both frame bases by one stride per beat
    always_ff @(posedge clk) begin
        if (start_ok) begin
            rd_addr <= csr.afu_read_frame;
            wr_addr <= csr.afu_write_frame;
        end else if (next_beat) begin
            rd_addr <= rd_addr + 64'(FRAME_STRIDE);
            wr_addr <= wr_addr + 64'(FRAME_STRIDE);
        end
    end

    always_comb begin
        mem_req.valid   = beat_valid;
        mem_req.rd_addr = rd_addr;
        mem_req.wr_addr = wr_addr;
    end

    // No beat may follow an edge at which the AFU was disabled
    a_no_beat_when_disabled: assert property (@(posedge clk) disable iff (rst)
        !$past(csr.afu_en) |-> !mem_req.valid);

endmodule

`default_nettype wire

/* rtl/qa_sreg_file.sv */
`timescale 1ns/1ps
`default_nettype none

// Status registers readable by the host through CSR_AFU_SREG_READ
module qa_sreg_file import qa_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  logic           csr_wr,
    input  t_csr_afu_state csr,
    input  logic           test_start,
    input  logic           test_done,
    output logic           sreg_rsp_valid,
    output logic [31:0]    sreg_rsp_data
);

    logic [31:0] wr_count;
    logic [31:0] start_count;
    logic [31:0] done_count;
    logic [31:0] sreg_value;

    // Every accepted host write, whatever its address
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_count <= '0;
        end else if (csr_wr) begin
            wr_count <= wr_count + 32'd1;
        end
    end

    // Test activity as reported by the test engine
    always_ff @(posedge clk) begin
        if (rst) begin
            start_count <= '0;
            done_count  <= '0;
        end else begin
            if (test_start) start_count <= start_count + 32'd1;
            if (test_done) done_count <= done_count + 32'd1;
        end
    end

    // Values read here are the ones held just before the response edge
    always_comb begin
        case (csr.afu_sreg_req.addr)
            2'd0:    sreg_value = wr_count;
            2'd1:    sreg_value = start_count;
            2'd2:    sreg_value = done_count;
            default: sreg_value = csr.afu_dsm_base[31:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sreg_rsp_valid <= 1'b0;
        end else begin
            sreg_rsp_valid <= csr.afu_sreg_req.enable;
        end
    end

    // Data only matters while valid is high
    always_ff @(posedge clk) begin
        if (csr.afu_sreg_req.enable) begin
            sreg_rsp_data <= sreg_value;
        end
    end

    // Each request is answered one cycle later and goes back to a host write
    a_rsp_follows_req: assert property (@(posedge clk) disable iff (rst)
        csr.afu_sreg_req.enable |=> sreg_rsp_valid && $past(csr_wr, 2));

endmodule

`default_nettype wire

/* rtl/qa_driver_csr.sv */
`timescale 1ns/1ps
`default_nettype none

// Turns host CSR writes into the CSR state seen by every consumer
module qa_driver_csr import qa_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  t_csr_write     wr,
    output t_csr_afu_state csr
);

    t_csr_wdata wdata;

    // Per-register write strobes
    logic hit_dsm_l;
    logic hit_dsm_h;
    logic hit_cntxt_l;
    logic hit_cntxt_h;
    logic hit_en;
    logic hit_test;
    logic hit_sreg;
    logic hit_rd_l;
    logic hit_rd_h;
    logic hit_wr_l;
    logic hit_wr_h;

    // The data word is only reinterpreted, the bits are never changed
    assign wdata.raw = wr.data;

    always_comb begin
        hit_dsm_l   = wr.valid && csr_addr_matches(wr, CSR_AFU_DSM_BASEL);
        hit_dsm_h   = wr.valid && csr_addr_matches(wr, CSR_AFU_DSM_BASEH);
        hit_cntxt_l = wr.valid && csr_addr_matches(wr, CSR_AFU_CNTXT_BASEL);
        hit_cntxt_h = wr.valid && csr_addr_matches(wr, CSR_AFU_CNTXT_BASEH);
        hit_en      = wr.valid && csr_addr_matches(wr, CSR_AFU_EN);
        hit_test    = wr.valid && csr_addr_matches(wr, CSR_AFU_ENABLE_TEST);
        hit_sreg    = wr.valid && csr_addr_matches(wr, CSR_AFU_SREG_READ);
        hit_rd_l    = wr.valid && csr_addr_matches(wr, CSR_AFU_READ_FRAME_BASEL);
        hit_rd_h    = wr.valid && csr_addr_matches(wr, CSR_AFU_READ_FRAME_BASEH);
        hit_wr_l    = wr.valid && csr_addr_matches(wr, CSR_AFU_WRITE_FRAME_BASEL);
        hit_wr_h    = wr.valid && csr_addr_matches(wr, CSR_AFU_WRITE_FRAME_BASEH);
    end

    // Base addresses are loaded half by half
    always_ff @(posedge clk) begin
        if (hit_dsm_l)   csr.afu_dsm_base[31:0]     <= wr.data;
        if (hit_dsm_h)   csr.afu_dsm_base[63:32]    <= wr.data;
        if (hit_cntxt_l) csr.afu_cntxt_base[31:0]   <= wr.data;
        if (hit_cntxt_h) csr.afu_cntxt_base[63:32]  <= wr.data;
        if (hit_rd_l)    csr.afu_read_frame[31:0]   <= wr.data;
        if (hit_rd_h)    csr.afu_read_frame[63:32]  <= wr.data;
        if (hit_wr_l)    csr.afu_write_frame[31:0]  <= wr.data;
        if (hit_wr_h)    csr.afu_write_frame[63:32] <= wr.data;
    end

    // A base counts as valid once its low half has been written
    always_ff @(posedge clk) begin
        if (rst) begin
            csr.afu_dsm_base_valid   <= 1'b0;
            csr.afu_cntxt_base_valid <= 1'b0;
        end else begin
            if (hit_dsm_l) csr.afu_dsm_base_valid <= 1'b1;
            if (hit_cntxt_l) csr.afu_cntxt_base_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr.afu_en              <= 1'b0;
            csr.afu_en_user_channel <= 1'b0;
        end else if (hit_en) begin
            csr.afu_en              <= wdata.en_cmd.afu_en;
            csr.afu_en_user_channel <= wdata.en_cmd.afu_en_user_channel;
        end
    end

    // Command fields stay around after the write, only the strobes drop
    always_ff @(posedge clk) begin
        if (hit_test) csr.afu_enable_test.count <= wdata.test_cmd.count;
        if (hit_sreg) csr.afu_sreg_req.addr <= wdata.sreg_cmd.addr;
    end

    // Each command write gives exactly one cycle of strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            csr.afu_enable_test.pulse <= 1'b0;
            csr.afu_sreg_req.enable   <= 1'b0;
        end else begin
            csr.afu_enable_test.pulse <= hit_test;
            csr.afu_sreg_req.enable   <= hit_sreg;
        end
    end

    // Every strobe cycle stands for a write of its own and holds that write's data
    a_test_pulse_per_write: assert property (@(posedge clk) disable iff (rst)
        csr.afu_enable_test.pulse
        |-> $past(wr.valid) && csr.afu_enable_test.count == $past(wdata.test_cmd.count));

    a_sreg_req_per_write: assert property (@(posedge clk) disable iff (rst)
        csr.afu_sreg_req.enable
        |-> $past(wr.valid) && csr.afu_sreg_req.addr == $past(wdata.sreg_cmd.addr));

endmodule

`default_nettype wire

/* common/qa_pkg.sv */
`default_nettype none

package qa_pkg;

    // Host CSR word addresses
    typedef logic [9:0] t_csr_addr;

    localparam t_csr_addr CSR_AFU_DSM_BASEL         = 10'h100;
    localparam t_csr_addr CSR_AFU_DSM_BASEH         = 10'h101;
    localparam t_csr_addr CSR_AFU_CNTXT_BASEL       = 10'h102;
    localparam t_csr_addr CSR_AFU_CNTXT_BASEH       = 10'h103;
    localparam t_csr_addr CSR_AFU_EN                = 10'h104;
    localparam t_csr_addr CSR_AFU_ENABLE_TEST       = 10'h105;
    localparam t_csr_addr CSR_AFU_SREG_READ         = 10'h106;
    localparam t_csr_addr CSR_AFU_READ_FRAME_BASEL  = 10'h108;
    localparam t_csr_addr CSR_AFU_READ_FRAME_BASEH  = 10'h109;
    localparam t_csr_addr CSR_AFU_WRITE_FRAME_BASEL = 10'h10a;
    localparam t_csr_addr CSR_AFU_WRITE_FRAME_BASEH = 10'h10b;

    // Byte distance between consecutive test beats
    localparam int unsigned FRAME_STRIDE = 64;

    // One host CSR write as it arrives on the strobe channel
    typedef struct packed {
        logic      valid;
        t_csr_addr addr;
        logic [31:0] data;
    } t_csr_write;

    // Index into the four status registers
    typedef logic [1:0] t_sreg_addr;

    // The same data word means different things depending on the target CSR
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29:0] rsvd;
            logic        afu_en_user_channel;
            logic        afu_en;
        } en_cmd;
        struct packed {
            logic [15:0] rsvd;
            logic [15:0] count;
        } test_cmd;
        struct packed {
            logic [29:0] rsvd;
            t_sreg_addr  addr;
        } sreg_cmd;
    } t_csr_wdata;

    typedef struct packed {
        logic       enable;
        t_sreg_addr addr;
    } t_sreg_req;

    // Test command as broadcast, the pulse marks the cycle of the write
    typedef struct packed {
        logic        pulse;
        logic [15:0] count;
    } t_afu_enable_test;

    typedef struct packed {
        logic [63:0]      afu_dsm_base;
        logic             afu_dsm_base_valid;
        logic [63:0]      afu_cntxt_base;
        logic             afu_cntxt_base_valid;
        logic             afu_en;
        logic             afu_en_user_channel;
        t_afu_enable_test afu_enable_test;
        t_sreg_req        afu_sreg_req;
        logic [63:0]      afu_read_frame;
        logic [63:0]      afu_write_frame;
    } t_csr_afu_state;

    // One beat of the test engine, a read and a write address together
    typedef struct packed {
        logic        valid;
        logic [63:0] rd_addr;
        logic [63:0] wr_addr;
    } t_mem_req;

    // True when the write targets the given CSR word
    function automatic logic csr_addr_matches(t_csr_write w, t_csr_addr a);
        return w.addr == a;
    endfunction

endpackage

`default_nettype wire
